//--- files.f
hw/csr_pkg.sv
hw/pkt_pkg.sv
hw/prbs23.sv
hw/csr_regs.sv
hw/header_gen.sv
hw/payload_gen.sv
hw/frame_sequencer.sv
hw/pkt_gen_top.sv
verif/pkt_gen_sva.sv
verif/pkt_gen_tests.sv
verif/pkt_gen_tb.sv

//--- hw/csr_pkg.sv
// Register map, seed reset values and configuration bundle of the packet generator
package csr_pkg;

   // Register addresses ------------
   localparam logic [7:0] addr_num_packets    = 8'h0;
   localparam logic [7:0] addr_random_length  = 8'h1;   // Retired, reads zero
   localparam logic [7:0] addr_random_payload = 8'h2;
   localparam logic [7:0] addr_start          = 8'h3;
   localparam logic [7:0] addr_stop           = 8'h4;
   localparam logic [7:0] addr_mac_sa0        = 8'h5;   // SA bits 31:0
   localparam logic [7:0] addr_mac_sa1        = 8'h6;   // SA bits 47:32
   localparam logic [7:0] addr_mac_da0        = 8'h7;   // DA bits 31:0
   localparam logic [7:0] addr_mac_da1        = 8'h8;   // DA bits 47:32
   localparam logic [7:0] addr_tx_pkt_cnt     = 8'h9;
   localparam logic [7:0] addr_seed0          = 8'ha;
   localparam logic [7:0] addr_seed1          = 8'hb;
   localparam logic [7:0] addr_seed2          = 8'hc;   // Only 28 bits used
   localparam logic [7:0] addr_pkt_length     = 8'hd;   // Payload bytes

   // Nonzero seeds keep the PRBS lanes out of the all-zero lock state
   localparam logic [31:0] seed0_rst = 32'h5EED0000;
   localparam logic [31:0] seed1_rst = 32'h5EED0001;
   localparam logic [31:0] seed2_rst = 32'h00025EED;

   typedef struct packed {
      logic [31:0] num_packets;    // 0 means run until stop
      logic [13:0] pkt_length;     // Payload byte count
      logic        random_payload; // 1 selects PRBS data
      logic        stop;
      logic [47:0] mac_sa;
      logic [47:0] mac_da;
      logic [91:0] seed;           // Four 23-bit lanes
   } csr_cfg_t;

endpackage

//--- hw/csr_regs.sv
// Control register file with start pulse generation and sent-packet counter
`timescale 1ns/10ps

module csr_regs (
   input  logic              clk,
   input  logic              reset,
   input  logic [7:0]        address,
   input  logic              write,
   input  logic              read,
   input  logic [31:0]       writedata,
   output logic [31:0]       readdata,
   input  logic              pkt_done,    // Last beat of a packet accepted
   output csr_pkg::csr_cfg_t cfg,
   output logic              start        // One-cycle run start
);
   import csr_pkg::*;

   logic        start_reg;   // Set by start write, self-clearing
   logic        start_d;     // Edge detect delay
   logic [31:0] tx_pkt_cnt;

   // Write decode ------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         cfg.num_packets    <= '0;
         cfg.pkt_length     <= '0;
         cfg.random_payload <= 1'b0;
         cfg.stop           <= 1'b0;
         cfg.mac_sa         <= '0;
         cfg.mac_da         <= '0;
         cfg.seed           <= {seed2_rst[27:0], seed1_rst, seed0_rst};
      end else if (write) begin
         case (address)
            addr_num_packets:    cfg.num_packets    <= writedata;
            addr_pkt_length:     cfg.pkt_length     <= writedata[13:0];
            addr_random_payload: cfg.random_payload <= writedata[0];
            addr_stop:           cfg.stop           <= writedata[0];
            addr_mac_sa0:        cfg.mac_sa[31:0]   <= writedata;
            addr_mac_sa1:        cfg.mac_sa[47:32]  <= writedata[15:0];
            addr_mac_da0:        cfg.mac_da[31:0]   <= writedata;
            addr_mac_da1:        cfg.mac_da[47:32]  <= writedata[15:0];
            addr_seed0:          cfg.seed[31:0]     <= writedata;
            addr_seed1:          cfg.seed[63:32]    <= writedata;
            addr_seed2:          cfg.seed[91:64]    <= writedata[27:0];
            default: ;
         endcase
      end
   end

   // Start pulse -------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         start_reg <= 1'b0;
         start_d   <= 1'b0;
      end else begin
         start_d <= start_reg;
         if (write && address == addr_start) begin
            start_reg <= writedata[0];
         end else begin
            start_reg <= 1'b0;   // Clears itself after one cycle
         end
      end
   end

   // Back-to-back start writes still give a single pulse
   assign start = start_reg & ~start_d;

   // Packets sent in the current run
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         tx_pkt_cnt <= '0;
      end else if (start) begin
         tx_pkt_cnt <= '0;
      end else if (pkt_done) begin
         tx_pkt_cnt <= tx_pkt_cnt + 32'd1;
      end
   end

   // Read mux, registered ----------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         readdata <= '0;
      end else if (read) begin
         case (address)
            addr_num_packets:    readdata <= cfg.num_packets;
            addr_random_length:  readdata <= '0;
            addr_random_payload: readdata <= {31'd0, cfg.random_payload};
            addr_start:          readdata <= {31'd0, start};
            addr_stop:           readdata <= {31'd0, cfg.stop};
            addr_mac_sa0:        readdata <= cfg.mac_sa[31:0];
            addr_mac_sa1:        readdata <= {16'd0, cfg.mac_sa[47:32]};
            addr_mac_da0:        readdata <= cfg.mac_da[31:0];
            addr_mac_da1:        readdata <= {16'd0, cfg.mac_da[47:32]};
            addr_tx_pkt_cnt:     readdata <= tx_pkt_cnt;
            addr_seed0:          readdata <= cfg.seed[31:0];
            addr_seed1:          readdata <= cfg.seed[63:32];
            addr_seed2:          readdata <= {4'd0, cfg.seed[91:64]};
            addr_pkt_length:     readdata <= {18'd0, cfg.pkt_length};
            default:             readdata <= '0;   // Unmapped
         endcase
      end
   end

endmodule

//--- hw/frame_sequencer.sv
// Packet FSM that orders header and payload beats into the registered output stream
`timescale 1ns/10ps

module frame_sequencer (
   input  logic              clk,
   input  logic              reset,
   input  logic              start,
   input  csr_pkg::csr_cfg_t cfg,
   input  pkt_pkg::beat_u    hdr0,
   input  pkt_pkg::beat_u    hdr1,
   input  pkt_pkg::beat_u    payload,
   input  logic              tx_ready,
   output pkt_pkg::st_beat_t tx,
   output logic              load,        // Run start to both producers
   output logic              advance,     // Payload word moved into tx
   output logic              next,        // Packet finished, bump sequence
   output logic              pkt_done
);
   import pkt_pkg::*;

   seq_state_t         state;        // Kind of beat held in tx
   seq_state_t         state_d;
   st_beat_t           tx_d;
   st_beat_t           sop_beat;     // Candidate beats
   st_beat_t           hdr1_beat;
   st_beat_t           pay_beat;
   logic [13:0]        bytes_left;   // Payload bytes not yet loaded
   logic [13:0]        bytes_d;
   logic [31:0]        pkt_cnt;      // Packets finished this run
   logic               accept;
   logic               pay_last;
   logic               run_done;
   logic [empty_w-1:0] last_empty;

   assign accept   = tx.valid & tx_ready;
   assign pkt_done = accept & tx.eop;
   assign next     = pkt_done;
   assign run_done = (cfg.num_packets != '0) && (pkt_cnt >= cfg.num_packets);

   // Last payload beat carries 1..8 bytes
   assign pay_last   = bytes_left <= 14'd8;
   assign last_empty = empty_w'(0) - bytes_left[empty_w-1:0];   // (8 - n mod 8) mod 8

   // Beat candidates ----------------------
   always_comb begin
      sop_beat       = '0;
      sop_beat.valid = 1'b1;
      sop_beat.sop   = 1'b1;
      sop_beat.data  = hdr0;

      hdr1_beat       = '0;
      hdr1_beat.valid = 1'b1;
      hdr1_beat.eop   = cfg.pkt_length == '0;   // No payload, ends here
      hdr1_beat.data  = hdr1;

      pay_beat       = '0;
      pay_beat.valid = 1'b1;
      pay_beat.eop   = pay_last;
      pay_beat.empty = pay_last ? last_empty : '0;
      pay_beat.data  = payload;
   end

   // Next state and next output beat ------
   always_comb begin
      state_d = state;
      tx_d    = tx;        // Hold under back-pressure
      bytes_d = bytes_left;
      load    = 1'b0;
      advance = 1'b0;
      case (state)
         idle: begin
            if (start) begin
               load    = 1'b1;
               state_d = pkt_pkg::hdr0;
               tx_d    = sop_beat;
            end
         end
         pkt_pkg::hdr0: begin
            if (accept) begin
               state_d = pkt_pkg::hdr1;
               tx_d    = hdr1_beat;
               bytes_d = cfg.pkt_length;
            end
         end
         pkt_pkg::hdr1, data: begin
            if (accept) begin
               if (tx.eop) begin
                  state_d    = gap;
                  tx_d.valid = 1'b0;
                  tx_d.sop   = 1'b0;
                  tx_d.eop   = 1'b0;
                  tx_d.empty = '0;
               end else begin
                  state_d = data;
                  tx_d    = pay_beat;
                  advance = 1'b1;
                  bytes_d = bytes_left - 14'd8;
               end
            end
         end
         gap: begin
            // Stop only takes effect here, so packets end whole
            if (cfg.stop || run_done) begin
               state_d = idle;
            end else begin
               state_d = pkt_pkg::hdr0;
               tx_d    = sop_beat;
            end
         end
         default: begin
            state_d = idle;
            tx_d    = '0;
         end
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state      <= idle;
         tx         <= '0;
         bytes_left <= '0;
         pkt_cnt    <= '0;
      end else begin
         state      <= state_d;
         tx         <= tx_d;
         bytes_left <= bytes_d;
         if (load) begin
            pkt_cnt <= '0;
         end else if (pkt_done) begin
            pkt_cnt <= pkt_cnt + 32'd1;
         end
      end
   end

endmodule

//--- hw/header_gen.sv
// Header beat builder holding the per-run packet sequence number
`timescale 1ns/10ps

module header_gen (
   input  logic           clk,
   input  logic           reset,
   input  logic           start,       // Run start, clears sequence
   input  logic           next,        // Packet completed
   input  logic [47:0]    mac_da,
   input  logic [47:0]    mac_sa,
   input  logic [13:0]    pkt_length,
   output pkt_pkg::beat_u hdr0,
   output pkt_pkg::beat_u hdr1
);

   logic [15:0] seq_num;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         seq_num <= '0;
      end else if (start) begin
         seq_num <= '0;
      end else if (next) begin
         seq_num <= seq_num + 16'd1;   // Wraps at 16 bits
      end
   end

   // Beat 0: DA in the top six bytes, then SA bytes 5 and 4
   always_comb begin
      hdr0.hdr0.da    = mac_da;
      hdr0.hdr0.sa_hi = mac_sa[47:32];
   end

   // Beat 1: rest of SA, payload length, sequence
   always_comb begin
      hdr1.hdr1.sa_lo = mac_sa[31:0];
      hdr1.hdr1.len   = {2'b00, pkt_length};
      hdr1.hdr1.seq   = seq_num;   // Already stepped by the time beat 1 loads
   end

endmodule

//--- hw/payload_gen.sv
// Payload word source, incrementing byte pattern or four PRBS23 lanes
`timescale 1ns/10ps

module payload_gen (
   input  logic           clk,
   input  logic           reset,
   input  logic           load,            // Run start
   input  logic           advance,         // Current word taken by sequencer
   input  logic           random_payload,
   input  logic [91:0]    seed,
   output pkt_pkg::beat_u beat
);
   import pkt_pkg::*;

   logic [91:0]       lane_state;   // Lanes 3..0, lane 0 lowest
   logic [data_w-1:0] inc_word;

   // PRBS lanes ------------------------------
   for (genvar g = 0; g < 4; g++) begin : g_lane
      prbs23 u_prbs (
         .clk    (clk),
         .reset  (reset),
         .load   (load),
         .enable (advance),
         .seed   (seed[g*23 +: 23]),
         .state  (lane_state[g*23 +: 23])
      );
   end

   // Incrementing pattern, runs on across packets of one run
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         inc_word <= inc_first;
      end else if (load) begin
         inc_word <= inc_first;
      end else if (advance) begin
         if (inc_word == inc_last) begin
            inc_word <= inc_first;          // Byte 0xFF reached
         end else begin
            inc_word <= inc_word + inc_step; // No byte carries before the wrap
         end
      end
   end

   // Byte 0 of the payload sits in bits 63:56
   assign beat = random_payload ? beat_u'(lane_state[data_w-1:0]) : beat_u'(inc_word);

endmodule

//--- hw/pkt_gen_top.sv
// Packet generator top, register block plus streaming beat path
`timescale 1ns/10ps

module pkt_gen_top (
   input  logic                        clk,
   input  logic                        reset,
   // Register bus
   input  logic [7:0]                  address,
   input  logic                        write,
   input  logic                        read,
   input  logic [31:0]                 writedata,
   output logic [31:0]                 readdata,
   // Output stream
   input  logic                        tx_ready,
   output logic [pkt_pkg::data_w-1:0]  tx_data,
   output logic                        tx_valid,
   output logic                        tx_sop,
   output logic                        tx_eop,
   output logic [pkt_pkg::empty_w-1:0] tx_empty
);
   import csr_pkg::*;
   import pkt_pkg::*;

   csr_cfg_t cfg;
   st_beat_t tx;
   beat_u    hdr0_w;
   beat_u    hdr1_w;
   beat_u    pay_w;
   logic     start;
   logic     load;
   logic     advance;
   logic     next;
   logic     pkt_done;

   csr_regs u_csr (
      .clk       (clk),
      .reset     (reset),
      .address   (address),
      .write     (write),
      .read      (read),
      .writedata (writedata),
      .readdata  (readdata),
      .pkt_done  (pkt_done),
      .cfg       (cfg),
      .start     (start)
   );

   header_gen u_hdr (
      .clk        (clk),
      .reset      (reset),
      .start      (load),
      .next       (next),
      .mac_da     (cfg.mac_da),
      .mac_sa     (cfg.mac_sa),
      .pkt_length (cfg.pkt_length),
      .hdr0       (hdr0_w),
      .hdr1       (hdr1_w)
   );

   payload_gen u_pay (
      .clk            (clk),
      .reset          (reset),
      .load           (load),
      .advance        (advance),
      .random_payload (cfg.random_payload),
      .seed           (cfg.seed),
      .beat           (pay_w)
   );

   frame_sequencer u_seq (
      .clk      (clk),
      .reset    (reset),
      .start    (start),
      .cfg      (cfg),
      .hdr0     (hdr0_w),
      .hdr1     (hdr1_w),
      .payload  (pay_w),
      .tx_ready (tx_ready),
      .tx       (tx),
      .load     (load),
      .advance  (advance),
      .next     (next),
      .pkt_done (pkt_done)
   );

   // Flatten stream beat
   assign tx_data  = tx.data;
   assign tx_valid = tx.valid;
   assign tx_sop   = tx.sop;
   assign tx_eop   = tx.eop;
   assign tx_empty = tx.empty;

endmodule

//--- hw/pkt_pkg.sv
// Stream beat formats, payload pattern constants and sequencer states
package pkt_pkg;

   localparam int data_w  = 64;  // Stream width
   localparam int empty_w = 3;   // Unused byte count on last beat

   // Incrementing payload ------------
   localparam logic [data_w-1:0] inc_first = 64'h0001020304050607;
   localparam logic [data_w-1:0] inc_step  = 64'h0808080808080808;
   localparam logic [data_w-1:0] inc_last  = 64'hF8F9FAFBFCFDFEFF; // Wraps to inc_first

   // First header beat, DA then upper SA
   typedef struct packed {
      logic [47:0] da;
      logic [15:0] sa_hi;
   } hdr0_t;

   // Second header beat
   typedef struct packed {
      logic [31:0] sa_lo;
      logic [15:0] len;
      logic [15:0] seq;
   } hdr1_t;

   // One data word, read as either header layout
   typedef union packed {
      hdr0_t hdr0;
      hdr1_t hdr1;
   } beat_u;

   typedef struct packed {
      logic               valid;
      logic               sop;
      logic               eop;
      logic [empty_w-1:0] empty;
      beat_u              data;
   } st_beat_t;

   typedef enum logic [2:0] {
      idle,
      hdr0,     // Output holds DA/SA beat
      hdr1,     // Output holds SA/len/seq beat
      data,     // Output holds a payload beat
      gap       // One idle cycle between packets
   } seq_state_t;

endpackage

//--- hw/prbs23.sv
// PRBS23 lane, x^23+x^18+1, stepping 23 bits per enable
`timescale 1ns/10ps

module prbs23 (
   input  logic        clk,
   input  logic        reset,
   input  logic        load,
   input  logic        enable,
   input  logic [22:0] seed,
   output logic [22:0] state
);

   logic [22:0] stepped;   // State after 23 shifts

   // Shift right, feedback into bit 22
   always_comb begin
      stepped = state;
      for (int i = 0; i < 23; i++) begin
         stepped = {stepped[18] ^ stepped[0], stepped[22:1]};
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= '0;
      end else if (load) begin
         state <= seed;   // Load wins over enable
      end else if (enable) begin
         state <= stepped;
      end
   end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the packet generator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module pkt_gen_tb -f files.f

output=$(./obj_dir/Vpkt_gen_tb 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "STATUS: PASS"; then
   exit 0
fi
echo "Simulation did not report a pass"
exit 1

//--- verif/pkt_gen_sva.sv
// Stream protocol checks on the frame sequencer output beat
`timescale 1ns/10ps

module pkt_gen_sva (
   input logic              clk,
   input logic              reset,
   input logic              tx_ready,
   input pkt_pkg::st_beat_t tx
);

   // Stalled beat keeps every field
   hold_on_stall: assert property (@(posedge clk) disable iff (reset)
      tx.valid && !tx_ready |=> $stable(tx))
      else $error("Output beat changed while tx_ready was low");

   // New sop only after an invalid cycle, or the same sop beat still stalled
   sop_first_beat: assert property (@(posedge clk) disable iff (reset)
      tx.valid && tx.sop |-> $past(!tx.valid) || $past(tx.valid && tx.sop && !tx_ready))
      else $error("sop seen on a beat that does not open a packet");

   empty_only_eop: assert property (@(posedge clk) disable iff (reset)
      tx.valid && !tx.eop |-> tx.empty == '0)   // Empty count belongs to the last beat
      else $error("Nonzero empty on a beat without eop");

endmodule

//--- verif/pkt_gen_tb.sv
// Testbench top for the packet generator, clock, reset, DUT and run verdict
`timescale 1ns/10ps

module pkt_gen_tb;
   import pkt_pkg::*;

   logic               clk = 1'b0;
   logic               reset;
   logic [7:0]         address;
   logic               write;
   logic               read;
   logic [31:0]        writedata;
   logic [31:0]        readdata;
   logic               tx_ready;
   logic [data_w-1:0]  tx_data;
   logic               tx_valid;
   logic               tx_sop;
   logic               tx_eop;
   logic [empty_w-1:0] tx_empty;
   logic               done;
   logic               failed;
   int                 cycles;

   always #50 clk = ~clk;   // 100 ns period

   pkt_gen_top dut (
      .clk       (clk),
      .reset     (reset),
      .address   (address),
      .write     (write),
      .read      (read),
      .writedata (writedata),
      .readdata  (readdata),
      .tx_ready  (tx_ready),
      .tx_data   (tx_data),
      .tx_valid  (tx_valid),
      .tx_sop    (tx_sop),
      .tx_eop    (tx_eop),
      .tx_empty  (tx_empty)
   );

   pkt_gen_tests tests (.*);

   // Protocol checks on the sequencer output
   bind frame_sequencer pkt_gen_sva sva (
      .clk      (clk),
      .reset    (reset),
      .tx_ready (tx_ready),
      .tx       (tx)
   );

   initial begin
      reset = 1'b1;
      repeat (2) @(posedge clk);   // Two cycles in reset
      #1;
      reset  = 1'b0;
      cycles = 0;
      while (!done && !failed && cycles < 50000) begin
         @(posedge clk);
         cycles++;
      end
      if (done && !failed) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         if (!failed) $display("Test sequence did not finish in time");
         $display("STATUS: FAIL");
         $fatal(1, "Run stopped on error");
      end
   end

endmodule

//--- verif/pkt_gen_tests.sv
// Directed test sequence for the packet generator with bus tasks, beat capture and packet checker
`timescale 1ns/10ps

module pkt_gen_tests (
   input  logic                        clk,
   input  logic                        reset,
   output logic [7:0]                  address,
   output logic                        write,
   output logic                        read,
   output logic [31:0]                 writedata,
   input  logic [31:0]                 readdata,
   output logic                        tx_ready,
   input  logic [pkt_pkg::data_w-1:0]  tx_data,
   input  logic                        tx_valid,
   input  logic                        tx_sop,
   input  logic                        tx_eop,
   input  logic [pkt_pkg::empty_w-1:0] tx_empty,
   output logic                        done,     // Sequence finished
   output logic                        failed    // First check failed
);
   import csr_pkg::*;
   import pkt_pkg::*;

   localparam logic [47:0] mac_da     = 48'h0A1B_2C3D_4E5F;
   localparam logic [47:0] mac_sa     = 48'h6655_4433_2211;
   localparam int          wait_limit = 4000;   // Cycles allowed per wait

   st_beat_t cap_q[$];    // Every accepted beat, in order
   st_beat_t exp_q[$];    // Predicted beats of one run
   st_beat_t ref_q[$];    // Beats of an earlier run
   st_beat_t beat_in;
   int       base;        // Index of the current run's first beat in cap_q
   logic     bp_on;       // Random back-pressure enable
   logic     ready_rand;

   assign tx_ready = ready_rand | ~bp_on;

   // Capture ------------------------------
   always @(posedge clk) begin
      if (tx_valid && tx_ready) begin
         beat_in = {1'b1, tx_sop, tx_eop, tx_empty, tx_data};
         cap_q.push_back(beat_in);
      end
   end

   // Ready pattern, new value 1 ns after each edge
   initial begin
      ready_rand = 1'b1;
      void'($urandom(32'h867fc662));
      forever begin
         @(posedge clk);
         #1;
         ready_rand = ($urandom % 4) != 0;   // High about 3 of 4 cycles
      end
   end

   task automatic report_error(input string msg);
      $display("%s", msg);
      failed = 1'b1;
      forever @(posedge clk);
   endtask

   // Bus tasks ----------------------------
   task automatic bus_write(input logic [7:0] a, input logic [31:0] d);
      @(posedge clk);
      #1;
      address   = a;
      writedata = d;
      write     = 1'b1;
      @(posedge clk);   // Sampled here
      #1;
      write = 1'b0;
   endtask

   task automatic bus_read(input logic [7:0] a, output logic [31:0] d);
      @(posedge clk);
      #1;
      address = a;
      read    = 1'b1;
      @(posedge clk);   // readdata registered on this edge
      #1;
      read = 1'b0;
      d    = readdata;
   endtask

   task automatic check_reg(input logic [7:0] a, input logic [31:0] want);
      logic [31:0] rd;
      bus_read(a, rd);
      assert (rd == want)
         else report_error($sformatf("Fail readdata at address %h: got %h, expected %h",
                                     a, rd, want));
   endtask

   // Packet model ------------------------
   function automatic logic [63:0] inc_word(input int n);
      logic [63:0] w;
      int          i;
      for (i = 0; i < 8; i++) begin
         w[63-8*i -: 8] = 8'((8*n + i) % 256);   // Byte 0 on top
      end
      return w;
   endfunction

   function automatic int eops_seen();
      int n;
      int i;
      n = 0;
      for (i = base; i < cap_q.size(); i++) begin
         if (cap_q[i].eop) n++;
      end
      return n;
   endfunction

   task automatic build_expected(input int npkt, input int len);
      int         p;
      int         k;
      int         nbeats;
      int         run_beat;   // Payload pattern continues across packets
      logic       last;
      logic [2:0] empt;
      exp_q.delete();
      nbeats   = (len + 7) / 8;
      run_beat = 0;
      for (p = 0; p < npkt; p++) begin
         exp_q.push_back({1'b1, 1'b1, 1'b0, 3'd0, mac_da, mac_sa[47:32]});
         exp_q.push_back({1'b1, 1'b0, len == 0, 3'd0, mac_sa[31:0], 16'(len), 16'(p)});
         for (k = 0; k < nbeats; k++) begin
            last = (k == nbeats - 1);
            empt = last ? 3'((8 - len % 8) % 8) : 3'd0;
            exp_q.push_back({1'b1, 1'b0, last, empt, inc_word(run_beat)});
            run_beat++;
         end
      end
   endtask

   task automatic check_beats(input bit chk_data);
      st_beat_t got;
      st_beat_t want;
      int       i;
      assert (cap_q.size() - base == exp_q.size())
         else report_error($sformatf("Fail accepted beat count: got %h, expected %h",
                                     cap_q.size() - base, exp_q.size()));
      for (i = 0; i < exp_q.size(); i++) begin
         got  = cap_q[base + i];
         want = exp_q[i];
         assert (got.sop == want.sop)
            else report_error($sformatf("Fail tx_sop at beat %0d: got %h, expected %h",
                                        i, got.sop, want.sop));
         assert (got.eop == want.eop)
            else report_error($sformatf("Fail tx_eop at beat %0d: got %h, expected %h",
                                        i, got.eop, want.eop));
         assert (got.empty == want.empty)
            else report_error($sformatf("Fail tx_empty at beat %0d: got %h, expected %h",
                                        i, got.empty, want.empty));
         assert (!chk_data || got.data == want.data)
            else report_error($sformatf("Fail tx_data at beat %0d: got %h, expected %h",
                                        i, got.data, want.data));
      end
   endtask

   task automatic wait_packets(input int npkt);
      int cycles;
      cycles = 0;
      while (eops_seen() < npkt && cycles < wait_limit) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      assert (eops_seen() >= npkt)
         else report_error($sformatf("Timeout while waiting for %0d packets", npkt));
   endtask

   task automatic setup_run(input int npkt, input int len, input bit rnd);
      bus_write(addr_num_packets, 32'(npkt));
      bus_write(addr_pkt_length, 32'(len));
      bus_write(addr_random_payload, {31'd0, rnd});
      bus_write(addr_stop, 32'd0);
   endtask

   task automatic run_and_check(input int npkt, input int len, input bit chk_data);
      base = cap_q.size();
      bus_write(addr_start, 32'd1);
      wait_packets(npkt);
      check_reg(addr_tx_pkt_cnt, 32'(npkt));   // Also lets a stray packet show up
      build_expected(npkt, len);
      check_beats(chk_data);
   endtask

   task automatic load_seeds();
      bus_write(addr_seed0, 32'h1234_5678);
      bus_write(addr_seed1, 32'h9ABC_DEF0);
      bus_write(addr_seed2, 32'h0ABC_1234);
   endtask

   // Directed tests ----------------------
   task automatic test_readback();
      logic [7:0]  addrs [11];
      logic [31:0] vals  [11];
      int          i;
      check_reg(addr_seed0, 32'h5EED_0000);   // Reset seeds
      check_reg(addr_seed1, 32'h5EED_0001);
      check_reg(addr_seed2, 32'h0002_5EED);
      check_reg(addr_tx_pkt_cnt, 32'd0);
      addrs = '{addr_num_packets, addr_random_payload, addr_stop, addr_mac_sa0, addr_mac_sa1,
                addr_mac_da0, addr_mac_da1, addr_seed0, addr_seed1, addr_seed2, addr_pkt_length};
      vals  = '{32'h0000_0007, 32'h1, 32'h1, mac_sa[31:0], {16'd0, mac_sa[47:32]},
                mac_da[31:0], {16'd0, mac_da[47:32]}, 32'hCAFE_0001, 32'h0BAD_F00D,
                32'h0123_4567, 32'h0000_2ABC};
      for (i = 0; i < 11; i++) begin
         bus_write(addrs[i], vals[i]);
         check_reg(addrs[i], vals[i]);
      end
      bus_write(addr_random_length, 32'hFFFF_FFFF);
      check_reg(addr_random_length, 32'd0);   // Retired register
      bus_write(8'h7F, 32'h5555_AAAA);
      check_reg(8'h7F, 32'd0);
   endtask

   task automatic test_short_lengths();
      setup_run(2, 0, 1'b0);
      run_and_check(2, 0, 1'b1);    // eop on hdr1
      setup_run(2, 16, 1'b0);
      run_and_check(2, 16, 1'b1);   // Full last word, empty 0
   endtask

   task automatic test_random();
      st_beat_t got;
      int       i;
      int       diffs;
      load_seeds();
      setup_run(2, 24, 1'b1);
      run_and_check(2, 24, 1'b0);
      ref_q.delete();
      diffs = 0;
      for (i = 0; i < exp_q.size(); i++) begin
         got = cap_q[base + i];
         ref_q.push_back(got);
         if (got.data != exp_q[i].data) diffs++;
      end
      assert (diffs > 0) else report_error("Random payload matches the incrementing pattern");
      load_seeds();   // Same seed, same data expected
      run_and_check(2, 24, 1'b0);
      for (i = 0; i < ref_q.size(); i++) begin
         got = cap_q[base + i];
         assert (got.data == ref_q[i].data)
            else report_error($sformatf("Fail tx_data at beat %0d of rerun: got %h, expected %h",
                                        i, got.data, ref_q[i].data));
      end
   endtask

   task automatic test_stop();
      int cycles;
      int npkt;
      setup_run(0, 8, 1'b0);   // Endless run
      base = cap_q.size();
      bus_write(addr_start, 32'd1);
      wait_packets(3);
      bus_write(addr_stop, 32'd1);
      cycles = 0;
      while (tx_valid && cycles < wait_limit) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      assert (!tx_valid) else report_error("Timeout while waiting for the run to stop");
      for (cycles = 0; cycles < 10; cycles++) begin
         @(posedge clk);
         #1;
         assert (!tx_valid)
            else report_error($sformatf("Fail tx_valid after stop: got %h, expected %h",
                                        tx_valid, 1'b0));
      end
      npkt = eops_seen();   // Whole packets only
      build_expected(npkt, 8);
      check_beats(1'b1);
      check_reg(addr_tx_pkt_cnt, 32'(npkt));
      bus_write(addr_stop, 32'd0);
   endtask

   // Sequence ----------------------------
   initial begin
      int cycles;
      address   = '0;
      write     = 1'b0;
      read      = 1'b0;
      writedata = '0;
      bp_on     = 1'b0;
      done      = 1'b0;
      failed    = 1'b0;
      base      = 0;
      cycles    = 0;
      while (reset !== 1'b0 && cycles < 100) begin
         @(posedge clk);
         cycles++;
      end
      assert (reset === 1'b0) else report_error("Reset was never released");
      test_readback();
      setup_run(3, 21, 1'b0);
      run_and_check(3, 21, 1'b1);   // Seq 0..2, empty 3
      test_short_lengths();
      setup_run(2, 13, 1'b0);
      bp_on = 1'b1;
      run_and_check(2, 13, 1'b1);   // Same beats as with ready high
      bp_on = 1'b0;
      test_random();
      test_stop();
      done = 1'b1;
   end

endmodule
